// ==== bench/tb_qpu_exu.sv ====
`timescale 1ns/10ps

module tb_qpu_exu;

  localparam int TIMEOUT = 1000;

  logic                 clk;
  logic                 i_reset;
  logic                 i_valid;
  qpu_pkg::instr_t      i_instr;
  logic                 i_trigger;
  logic                 o_ready;
  logic                 o_active;
  logic                 o_wbck_valid;
  qpu_pkg::rfidx_t      o_wbck_rdidx;
  qpu_pkg::xlen_t       o_wbck_data;
  logic                 o_timer_ena;
  qpu_pkg::time_t       o_timer;
  qpu_pkg::event_mask_t o_trigger_valid;
  qpu_pkg::event_data_t o_trigger_data;

  // Reference model
  logic [31:0] m_rf [16];
  logic [31:0] m_stage_word;
  logic [3:0]  m_stage_mask;
  logic [35:0] exp_wb [$];   // {rd, data}
  logic [51:0] exp_ev [$];   // {time, word, mask}
  int          last_emit;    // Timer value of the previous emission
  int          errors;
  int          checks;
  int          stalls;
  logic [31:0] held;
  string       test_name;

  qpu_exu #(
    .QUEUE_DEPTH (4)
  ) dut0 (
    .clk             (clk),
    .i_reset         (i_reset),
    .i_valid         (i_valid),
    .o_ready         (o_ready),
    .i_instr         (i_instr),
    .i_trigger       (i_trigger),
    .o_active        (o_active),
    .o_wbck_valid    (o_wbck_valid),
    .o_wbck_rdidx    (o_wbck_rdidx),
    .o_wbck_data     (o_wbck_data),
    .o_timer_ena     (o_timer_ena),
    .o_timer         (o_timer),
    .o_trigger_valid (o_trigger_valid),
    .o_trigger_data  (o_trigger_data)
  );

  always #5 clk = ~clk;

  function automatic logic [31:0] make_instr(logic [3:0] op, logic [3:0] rd, logic [3:0] rs1,
                                             logic [3:0] rs2, logic [15:0] imm);
    return {op, rd, rs1, rs2, imm};
  endfunction

  task automatic expect_bit(input string what, input logic exp, input logic act);
    checks++;
    if (act !== exp) begin
      $display("** Error %s %s expected %b actual %b", test_name, what, exp, act);
      errors++;
    end
  endtask

  ////////////////////
  // Model update on acceptance

  task automatic model_accept(input logic [31:0] ins);
    logic [3:0]  op;
    logic [3:0]  rd;
    logic [31:0] a;
    logic [31:0] b;
    logic [15:0] imm;
    logic [31:0] res;
    op  = ins[31:28];
    rd  = ins[27:24];
    a   = m_rf[ins[23:20]];
    b   = m_rf[ins[19:16]];
    imm = ins[15:0];
    res = '0;
    case (op)
      4'h1: res = a + b;
      4'h2: res = a - b;
      4'h3: res = a & b;
      4'h4: res = a | b;
      4'h5: res = a ^ b;
      4'h6: res = a + {{16{imm[15]}}, imm};
      4'h7: res = {imm, 16'h0000};
      4'h8: begin
        for (int i = 0; i < 4; i++) begin
          if (imm[i]) m_stage_word[8*i +: 8] = a[7:0];
        end
        m_stage_mask = m_stage_mask | imm[3:0];
      end
      4'h9: begin
        exp_ev.push_back({16'(a[15:0] + imm), m_stage_word, m_stage_mask});
        m_stage_mask = '0;   // Bytes stay
      end
      default: ;
    endcase
    if (op >= 4'h1 && op <= 4'h7 && rd != 4'h0) begin
      m_rf[rd] = res;
      exp_wb.push_back({rd, res});
    end
  endtask

  ////////////////////
  // Stimulus helpers

  // Starts and returns on a falling edge
  task automatic issue(input logic [31:0] ins);
    int n;
    n = 0;
    i_valid = 1'b1;
    i_instr = ins;
    #1;
    while (!o_ready && n < TIMEOUT) begin
      @(negedge clk);
      #1;
      n++;
    end
    stalls = n;
    if (!o_ready) begin
      $display("%s: instruction %h was never accepted", test_name, ins);
      errors++;
    end else begin
      model_accept(ins);
    end
    @(negedge clk);
    i_valid = 1'b0;
  endtask

  task automatic pulse_trigger;
    last_emit = 0;
    i_trigger = 1'b1;
    @(negedge clk);
    i_trigger = 1'b0;
  endtask

  task automatic wait_drain;
    int n;
    n = 0;
    while ((exp_wb.size() != 0 || exp_ev.size() != 0) && n < TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    if (exp_wb.size() != 0 || exp_ev.size() != 0) begin
      $display("%s: timed out with %0d write-backs and %0d events still expected",
               test_name, exp_wb.size(), exp_ev.size());
      errors++;
    end
  endtask

  task automatic apply_reset;
    i_reset   = 1'b1;
    i_valid   = 1'b0;
    i_trigger = 1'b0;
    repeat (5) @(negedge clk);
    i_reset = 1'b0;
    for (int i = 0; i < 16; i++) m_rf[i] = '0;
    m_stage_word = '0;
    m_stage_mask = '0;
    exp_wb.delete();
    exp_ev.delete();
    last_emit = 0;
  endtask

  ////////////////////
  // Output monitor

  always @(negedge clk) begin
    logic [35:0] wb;
    logic [51:0] ev;
    int          exp_t;
    if (!i_reset && o_wbck_valid) begin
      checks++;
      if (exp_wb.size() == 0) begin
        $display("%s: write-back to r%0d with nothing pending", test_name, o_wbck_rdidx);
        errors++;
      end else begin
        wb = exp_wb.pop_front();
        if (o_wbck_rdidx !== wb[35:32]) begin
          $display("** Error %s rd expected %0d actual %0d", test_name, wb[35:32], o_wbck_rdidx);
          errors++;
        end
        if (o_wbck_data !== wb[31:0]) begin
          $display("** Error %s data expected %h actual %h", test_name, wb[31:0], o_wbck_data);
          errors++;
        end
      end
    end
    if (!i_reset && o_trigger_valid != '0) begin
      checks++;
      if (exp_ev.size() == 0) begin
        $display("%s: trigger %h fired with no entry queued", test_name, o_trigger_valid);
        errors++;
      end else begin
        ev = exp_ev.pop_front();
        exp_t = (int'(ev[51:36]) > last_emit) ? int'(ev[51:36]) + 1 : last_emit + 1;
        last_emit = exp_t;
        if (o_trigger_valid !== ev[3:0]) begin
          $display("** Error %s mask expected %h actual %h", test_name, ev[3:0], o_trigger_valid);
          errors++;
        end
        if (o_trigger_data !== ev[35:4]) begin
          $display("** Error %s word expected %h actual %h", test_name, ev[35:4], o_trigger_data);
          errors++;
        end
        if (int'(o_timer) != exp_t) begin
          $display("** Error %s timer expected %0d actual %0d", test_name, exp_t, o_timer);
          errors++;
        end
      end
    end
  end

  ////////////////////
  // Test sequence

  initial begin
    clk       = 1'b0;
    i_instr   = '0;
    errors    = 0;
    checks    = 0;
    stalls    = 0;
    test_name = "reset";
    void'($urandom(32'h668));
    apply_reset;
    #1;
    expect_bit("o_timer_ena", 1'b0, o_timer_ena);
    expect_bit("o_trigger_valid", 1'b0, |o_trigger_valid);
    expect_bit("o_wbck_valid", 1'b0, o_wbck_valid);
    expect_bit("o_active", 1'b0, o_active);
    @(negedge clk);

    test_name = "alu";
    repeat (200) begin
      issue(make_instr(4'(1 + $urandom_range(6)), 4'($urandom), 4'($urandom),
                       4'($urandom), 16'($urandom)));
    end
    wait_drain;

    test_name = "hazard";   // Reader right behind its writer
    for (int k = 1; k < 8; k++) begin
      issue(make_instr(qpu_pkg::OP_ADDI, 4'(k), 4'h0, 4'h0, 16'($urandom)));
      issue(make_instr(qpu_pkg::OP_ADD, 4'(k + 8), 4'(k), 4'(k), 16'h0000));
      checks++;
      if (stalls != 1) begin
        $display("** Error %s stall cycles expected 1 actual %0d", test_name, stalls);
        errors++;
      end
    end
    wait_drain;

    apply_reset;
    test_name = "event";
    for (int k = 1; k < 8; k++) begin
      issue(make_instr(qpu_pkg::OP_ADDI, 4'(k), 4'h0, 4'h0, 16'($urandom)));
    end
    issue(make_instr(qpu_pkg::OP_ADDI, 4'h8, 4'h0, 4'h0, 16'(1 + $urandom_range(4))));
    for (int r = 0; r < 3; r++) begin
      repeat (1 + $urandom_range(3)) begin
        issue(make_instr(qpu_pkg::OP_EVENT, 4'h0, 4'($urandom), 4'h0,
                         16'(1 + $urandom_range(14))));
      end
      issue(make_instr(qpu_pkg::OP_TIME, 4'h0, 4'h8, 4'h0, 16'(10 * r + $urandom_range(7))));
    end
    @(negedge clk);
    #1;
    expect_bit("o_active", 1'b1, o_active);   // Only the queue holds work
    @(negedge clk);
    pulse_trigger;
    wait_drain;

    apply_reset;
    test_name = "backpressure";
    issue(make_instr(qpu_pkg::OP_ADDI, 4'h3, 4'h0, 4'h0, 16'($urandom)));
    for (int k = 0; k < 5; k++) begin
      issue(make_instr(qpu_pkg::OP_EVENT, 4'h0, 4'h3, 4'h0, 16'(1 + $urandom_range(14))));
      if (k < 4) issue(make_instr(qpu_pkg::OP_TIME, 4'h0, 4'h0, 4'h0,
                                  16'(10 * k + 5 + $urandom_range(3))));
    end
    held    = make_instr(qpu_pkg::OP_TIME, 4'h0, 4'h0, 4'h0, 16'd60);
    i_valid = 1'b1;   // Queue full and timer idle
    i_instr = held;
    for (int c = 0; c < 20; c++) begin
      #1;
      expect_bit("o_ready", 1'b0, o_ready);
      @(negedge clk);
    end
    pulse_trigger;
    issue(held);
    wait_drain;

    $display("Checks: %0d  Errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

// ==== common/qpu_dec_if.sv ====
`timescale 1ns/10ps

// Decoded fields, decode to dispatch and ALU
interface qpu_dec_if;

  qpu_pkg::opcode_e op;
  qpu_pkg::rfidx_t  rd;
  qpu_pkg::rfidx_t  rs1;
  qpu_pkg::rfidx_t  rs2;
  qpu_pkg::imm_t    imm;
  logic             rdwen;   // Writes rd
  logic             rs1en;   // Reads rs1
  logic             rs2en;   // Reads rs2

  modport dec (
    output op, rd, rs1, rs2, imm, rdwen, rs1en, rs2en
  );

  modport disp (
    input op, rs1, rs2, rs1en, rs2en
  );

  modport alu (
    input op, rd, imm, rdwen
  );

endinterface

// ==== common/qpu_evq_if.sv ====
`timescale 1ns/10ps

// Staging writes and time-point pushes into the event queue
interface qpu_evq_if;

  logic                 ev_wen;      // Staging write strobe
  qpu_pkg::event_mask_t ev_mask;     // Channels to write
  qpu_pkg::event_word_t ev_word;
  logic                 push;        // Time-point strobe
  qpu_pkg::time_t       push_time;
  logic                 full;        // Counts the push in flight

  modport alu (
    output ev_wen, ev_mask, ev_word, push, push_time
  );

  modport evq (
    input  ev_wen, ev_mask, ev_word, push, push_time,
    output full
  );

  modport disp (
    input full
  );

endinterface

// ==== common/qpu_pkg.sv ====
package qpu_pkg;

  ////////////////////
  // Widths

  localparam int XLEN             = 32;
  localparam int INSTR_WIDTH      = 32;
  localparam int RFIDX_WIDTH      = 4;
  localparam int RF_DEPTH         = 1 << RFIDX_WIDTH;
  localparam int IMM_WIDTH        = 16;
  localparam int TIME_WIDTH       = 16;
  localparam int EVENT_NUM        = 4;   // Trigger channels
  localparam int EVENT_WIRE_WIDTH = 8;   // Bits per channel word
  localparam int OPCODE_WIDTH     = 4;

  ////////////////////
  // Instruction field positions

  localparam int OPCODE_LSB = 28;   // Bits 31..28
  localparam int RD_LSB     = 24;   // Bits 27..24
  localparam int RS1_LSB    = 20;   // Bits 23..20
  localparam int RS2_LSB    = 16;   // Bits 19..16
  localparam int IMM_LSB    = 0;    // Bits 15..0

  ////////////////////
  // Types

  typedef logic [XLEN-1:0]                       xlen_t;
  typedef logic [INSTR_WIDTH-1:0]                instr_t;
  typedef logic [RFIDX_WIDTH-1:0]                rfidx_t;
  typedef logic [IMM_WIDTH-1:0]                  imm_t;
  typedef logic [TIME_WIDTH-1:0]                 time_t;
  typedef logic [EVENT_NUM-1:0]                  event_mask_t;
  typedef logic [EVENT_WIRE_WIDTH-1:0]           event_word_t;

  // Channel i sits in bits 8i+7 to 8i
  typedef logic [EVENT_NUM*EVENT_WIRE_WIDTH-1:0] event_data_t;

  // Opcode encodings
  typedef enum logic [OPCODE_WIDTH-1:0] {
    OP_NOP   = 4'h0,
    OP_ADD   = 4'h1,
    OP_SUB   = 4'h2,
    OP_AND   = 4'h3,
    OP_OR    = 4'h4,
    OP_XOR   = 4'h5,
    OP_ADDI  = 4'h6,
    OP_LUI   = 4'h7,
    OP_EVENT = 4'h8,   // Fill staging register
    OP_TIME  = 4'h9    // Push time point
  } opcode_e;

endpackage

// ==== evq/qpu_exu_evq.sv ====
`timescale 1ns/10ps

module qpu_exu_evq #(
  parameter int QUEUE_DEPTH = 4
) (
  input  logic                 clk,
  input  logic                 i_reset,
  input  logic                 i_trigger,
  output logic                 o_timer_ena,
  output qpu_pkg::time_t       o_timer,
  output qpu_pkg::event_mask_t o_trigger_valid,   // One-cycle release pulse
  output qpu_pkg::event_data_t o_trigger_data,
  output logic                 o_empty,
  qpu_evq_if.evq               evq
);

  localparam int PTR_WIDTH = $clog2(QUEUE_DEPTH);
  localparam int CNT_WIDTH = $clog2(QUEUE_DEPTH + 1);
  localparam int WW        = qpu_pkg::EVENT_WIRE_WIDTH;

  qpu_pkg::event_data_t stage_word;
  qpu_pkg::event_mask_t stage_mask;
  qpu_pkg::time_t       q_time [QUEUE_DEPTH];
  qpu_pkg::event_data_t q_word [QUEUE_DEPTH];
  qpu_pkg::event_mask_t q_mask [QUEUE_DEPTH];
  logic [PTR_WIDTH-1:0] wr_ptr;
  logic [PTR_WIDTH-1:0] rd_ptr;
  logic [CNT_WIDTH-1:0] count;
  logic                 pop;

  ////////////////////
  // Staging register

  always_ff @(posedge clk) begin
    if (i_reset) begin
      stage_word <= '0;
      stage_mask <= '0;
    end else if (evq.ev_wen) begin
      for (int i = 0; i < qpu_pkg::EVENT_NUM; i++) begin
        if (evq.ev_mask[i]) begin
          stage_word[i*WW +: WW] <= evq.ev_word;
        end
      end
      stage_mask <= stage_mask | evq.ev_mask;
    end else if (evq.push) begin
      stage_mask <= '0;   // Channel bytes are kept
    end
  end

  ////////////////////
  // Timestamped FIFO

  always_ff @(posedge clk) begin
    if (evq.push) begin
      q_time[wr_ptr] <= evq.push_time;
      q_word[wr_ptr] <= stage_word;
      q_mask[wr_ptr] <= stage_mask;
    end
  end

  always_ff @(posedge clk) begin
    if (i_reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (evq.push) begin
        wr_ptr <= (wr_ptr == PTR_WIDTH'(QUEUE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PTR_WIDTH'(QUEUE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      count <= count + CNT_WIDTH'(evq.push) - CNT_WIDTH'(pop);
    end
  end

  assign o_empty  = (count == '0);
  assign evq.full = ((count + CNT_WIDTH'(evq.push)) == CNT_WIDTH'(QUEUE_DEPTH));

  ////////////////////
  // Timer and release

  always_ff @(posedge clk) begin
    if (i_reset) begin
      o_timer_ena <= 1'b0;
      o_timer     <= '0;
    end else if (i_trigger) begin
      o_timer_ena <= 1'b1;   // Restart from zero
      o_timer     <= '0;
    end else if (o_timer_ena) begin
      o_timer     <= o_timer + 1'b1;
    end
  end

  assign pop = o_timer_ena & ~o_empty & (q_time[rd_ptr] <= o_timer);

  // Head shows up one cycle after its pop
  always_ff @(posedge clk) begin
    if (i_reset || !pop) begin
      o_trigger_valid <= '0;
      o_trigger_data  <= '0;
    end else begin
      o_trigger_valid <= q_mask[rd_ptr];
      o_trigger_data  <= q_word[rd_ptr];
    end
  end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary -Wno-fatal -f tb.f --top-module tb_qpu_exu -o tb_qpu_exu \
  && ./obj_dir/tb_qpu_exu > sim.log 2>&1 \
  || { echo "Build or simulation error"; exit 1; }
grep -q "Verification failed" sim.log && { cat sim.log; exit 1; }
grep -q "Verification passed" sim.log || { echo "No result found in sim.log"; exit 1; }
echo "Simulation passed"
exit 0

// ==== tb.f ====
common/qpu_pkg.sv
common/qpu_dec_if.sv
common/qpu_evq_if.sv
verilog/qpu_exu_decode.sv
verilog/qpu_exu_regfile.sv
verilog/qpu_exu_disp.sv
verilog/qpu_exu_alu.sv
evq/qpu_exu_evq.sv
verilog/qpu_exu.sv
bench/tb_qpu_exu.sv

// ==== verilog/qpu_exu.sv ====
`timescale 1ns/10ps

module qpu_exu #(
  parameter int QUEUE_DEPTH = 4
) (
  input  logic                 clk,
  input  logic                 i_reset,

  input  logic                 i_valid,          // Instruction handshake
  output logic                 o_ready,
  input  qpu_pkg::instr_t      i_instr,

  input  logic                 i_trigger,        // Starts the timer
  output logic                 o_active,

  output logic                 o_wbck_valid,
  output qpu_pkg::rfidx_t      o_wbck_rdidx,
  output qpu_pkg::xlen_t       o_wbck_data,

  output logic                 o_timer_ena,
  output qpu_pkg::time_t       o_timer,
  output qpu_pkg::event_mask_t o_trigger_valid,
  output qpu_pkg::event_data_t o_trigger_data
);

  qpu_dec_if dec_bus ();
  qpu_evq_if evq_bus ();

  qpu_pkg::xlen_t rf_rs1;
  qpu_pkg::xlen_t rf_rs2;
  logic           disp_issue;
  logic           queue_empty;

  ////////////////////
  // Front end

  qpu_exu_decode u_qpu_exu_decode (
    .i_instr (i_instr),
    .dec     (dec_bus)
  );

  qpu_exu_regfile u_qpu_exu_regfile (
    .clk          (clk),
    .i_reset      (i_reset),
    .i_rs1idx     (dec_bus.rs1),
    .i_rs2idx     (dec_bus.rs2),
    .o_rs1        (rf_rs1),
    .o_rs2        (rf_rs2),
    .i_wbck_valid (o_wbck_valid),
    .i_wbck_rdidx (o_wbck_rdidx),
    .i_wbck_data  (o_wbck_data)
  );

  qpu_exu_disp u_qpu_exu_disp (
    .i_valid      (i_valid),
    .o_ready      (o_ready),
    .o_issue      (disp_issue),
    .i_wbck_valid (o_wbck_valid),
    .i_wbck_rdidx (o_wbck_rdidx),
    .dec          (dec_bus),
    .evq          (evq_bus)
  );

  ////////////////////
  // Execute and event queue

  qpu_exu_alu u_qpu_exu_alu (
    .clk          (clk),
    .i_reset      (i_reset),
    .i_issue      (disp_issue),
    .i_rs1        (rf_rs1),
    .i_rs2        (rf_rs2),
    .o_wbck_valid (o_wbck_valid),
    .o_wbck_rdidx (o_wbck_rdidx),
    .o_wbck_data  (o_wbck_data),
    .dec          (dec_bus),
    .evq          (evq_bus)
  );

  qpu_exu_evq #(
    .QUEUE_DEPTH (QUEUE_DEPTH)
  ) u_qpu_exu_evq (
    .clk             (clk),
    .i_reset         (i_reset),
    .i_trigger       (i_trigger),
    .o_timer_ena     (o_timer_ena),
    .o_timer         (o_timer),
    .o_trigger_valid (o_trigger_valid),
    .o_trigger_data  (o_trigger_data),
    .o_empty         (queue_empty),
    .evq             (evq_bus)
  );

  // Busy while anything is offered, in flight or queued
  assign o_active = i_valid | o_wbck_valid | evq_bus.ev_wen | evq_bus.push | ~queue_empty;

endmodule

// ==== verilog/qpu_exu_alu.sv ====
`timescale 1ns/10ps

module qpu_exu_alu (
  input  logic            clk,
  input  logic            i_reset,
  input  logic            i_issue,
  input  qpu_pkg::xlen_t  i_rs1,
  input  qpu_pkg::xlen_t  i_rs2,

  output logic            o_wbck_valid,   // One-cycle write-back
  output qpu_pkg::rfidx_t o_wbck_rdidx,
  output qpu_pkg::xlen_t  o_wbck_data,

  qpu_dec_if.alu          dec,
  qpu_evq_if.alu          evq
);

  qpu_pkg::xlen_t imm_sext;
  qpu_pkg::xlen_t alu_res;
  logic           is_event;
  logic           is_time;

  assign imm_sext = {{(qpu_pkg::XLEN - qpu_pkg::IMM_WIDTH){dec.imm[qpu_pkg::IMM_WIDTH-1]}},
                     dec.imm};

  assign is_event = (dec.op == qpu_pkg::OP_EVENT);
  assign is_time  = (dec.op == qpu_pkg::OP_TIME);

  ////////////////////
  // Result select

  always_comb begin
    case (dec.op)
      qpu_pkg::OP_ADD:  alu_res = i_rs1 + i_rs2;
      qpu_pkg::OP_SUB:  alu_res = i_rs1 - i_rs2;
      qpu_pkg::OP_AND:  alu_res = i_rs1 & i_rs2;
      qpu_pkg::OP_OR:   alu_res = i_rs1 | i_rs2;
      qpu_pkg::OP_XOR:  alu_res = i_rs1 ^ i_rs2;
      qpu_pkg::OP_ADDI: alu_res = i_rs1 + imm_sext;
      qpu_pkg::OP_LUI:  alu_res = {dec.imm, {(qpu_pkg::XLEN - qpu_pkg::IMM_WIDTH){1'b0}}};
      default:          alu_res = '0;
    endcase
  end

  // Strobes, at most one per accepted instruction
  always_ff @(posedge clk) begin
    if (i_reset) begin
      o_wbck_valid <= 1'b0;
      evq.ev_wen   <= 1'b0;
      evq.push     <= 1'b0;
    end else begin
      o_wbck_valid <= i_issue & dec.rdwen;
      evq.ev_wen   <= i_issue & is_event;
      evq.push     <= i_issue & is_time;
    end
  end

  ////////////////////
  // Payload

  always_ff @(posedge clk) begin
    if (i_issue) begin
      o_wbck_rdidx  <= dec.rd;
      o_wbck_data   <= alu_res;
      evq.ev_mask   <= dec.imm[qpu_pkg::EVENT_NUM-1:0];          // Channel select
      evq.ev_word   <= i_rs1[qpu_pkg::EVENT_WIRE_WIDTH-1:0];
      evq.push_time <= i_rs1[qpu_pkg::TIME_WIDTH-1:0] + dec.imm;  // Wraps at 2^16
    end
  end

endmodule

// ==== verilog/qpu_exu_decode.sv ====
`timescale 1ns/10ps

module qpu_exu_decode (
  input  qpu_pkg::instr_t i_instr,
  qpu_dec_if.dec          dec
);

  logic [qpu_pkg::OPCODE_WIDTH-1:0] opcode_field;
  qpu_pkg::opcode_e                 op;
  logic                             is_alu_type;
  logic                             is_reg_reg;

  assign opcode_field = i_instr[qpu_pkg::OPCODE_LSB +: qpu_pkg::OPCODE_WIDTH];

  // Unknown codes fall back to NOP
  always_comb begin
    case (opcode_field)
      qpu_pkg::OP_ADD,
      qpu_pkg::OP_SUB,
      qpu_pkg::OP_AND,
      qpu_pkg::OP_OR,
      qpu_pkg::OP_XOR,
      qpu_pkg::OP_ADDI,
      qpu_pkg::OP_LUI,
      qpu_pkg::OP_EVENT,
      qpu_pkg::OP_TIME: op = qpu_pkg::opcode_e'(opcode_field);
      default:          op = qpu_pkg::OP_NOP;
    endcase
  end

  ////////////////////
  // Operand fields

  assign dec.op  = op;
  assign dec.rd  = i_instr[qpu_pkg::RD_LSB  +: qpu_pkg::RFIDX_WIDTH];
  assign dec.rs1 = i_instr[qpu_pkg::RS1_LSB +: qpu_pkg::RFIDX_WIDTH];
  assign dec.rs2 = i_instr[qpu_pkg::RS2_LSB +: qpu_pkg::RFIDX_WIDTH];
  assign dec.imm = i_instr[qpu_pkg::IMM_LSB +: qpu_pkg::IMM_WIDTH];

  // ADD through LUI produce a register result
  assign is_alu_type = op inside {qpu_pkg::OP_ADD, qpu_pkg::OP_SUB, qpu_pkg::OP_AND,
                                  qpu_pkg::OP_OR, qpu_pkg::OP_XOR, qpu_pkg::OP_ADDI,
                                  qpu_pkg::OP_LUI};

  assign is_reg_reg = op inside {qpu_pkg::OP_ADD, qpu_pkg::OP_SUB, qpu_pkg::OP_AND,
                                 qpu_pkg::OP_OR, qpu_pkg::OP_XOR};

  ////////////////////
  // Enables

  assign dec.rdwen = is_alu_type & (dec.rd != '0);   // r0 is never written
  assign dec.rs1en = (op != qpu_pkg::OP_NOP) & (op != qpu_pkg::OP_LUI);
  assign dec.rs2en = is_reg_reg;

endmodule

// ==== verilog/qpu_exu_disp.sv ====
`timescale 1ns/10ps

module qpu_exu_disp (
  input  logic            i_valid,
  output logic            o_ready,
  output logic            o_issue,        // Accepted this cycle

  input  logic            i_wbck_valid,   // Write in flight
  input  qpu_pkg::rfidx_t i_wbck_rdidx,

  qpu_dec_if.disp         dec,
  qpu_evq_if.disp         evq
);

  logic wbck_live;
  logic rs1_hit;
  logic rs2_hit;
  logic raw_stall;
  logic full_stall;

  ////////////////////
  // Read-after-write check

  // The register file is written at the end of the write-back cycle,
  // so a reader in that cycle waits one cycle
  assign wbck_live = i_wbck_valid & (i_wbck_rdidx != '0);

  assign rs1_hit   = dec.rs1en & (dec.rs1 == i_wbck_rdidx);
  assign rs2_hit   = dec.rs2en & (dec.rs2 == i_wbck_rdidx);
  assign raw_stall = wbck_live & (rs1_hit | rs2_hit);

  ////////////////////
  // Queue back-pressure

  assign full_stall = (dec.op == qpu_pkg::OP_TIME) & evq.full;   // TIME waits here

  assign o_ready = ~(raw_stall | full_stall);
  assign o_issue = i_valid & o_ready;

endmodule

// ==== verilog/qpu_exu_regfile.sv ====
`timescale 1ns/10ps

module qpu_exu_regfile (
  input  logic            clk,
  input  logic            i_reset,

  input  qpu_pkg::rfidx_t i_rs1idx,
  input  qpu_pkg::rfidx_t i_rs2idx,
  output qpu_pkg::xlen_t  o_rs1,
  output qpu_pkg::xlen_t  o_rs2,

  input  logic            i_wbck_valid,   // Write port
  input  qpu_pkg::rfidx_t i_wbck_rdidx,
  input  qpu_pkg::xlen_t  i_wbck_data
);

  qpu_pkg::xlen_t rf [qpu_pkg::RF_DEPTH];

  always_ff @(posedge clk) begin
    if (i_reset) begin
      for (int i = 0; i < qpu_pkg::RF_DEPTH; i++) begin
        rf[i] <= '0;
      end
    end else if (i_wbck_valid && (i_wbck_rdidx != '0)) begin
      rf[i_wbck_rdidx] <= i_wbck_data;   // r0 stays zero
    end
  end

  // Combinational read, r0 forced to zero
  assign o_rs1 = (i_rs1idx == '0) ? '0 : rf[i_rs1idx];
  assign o_rs2 = (i_rs2idx == '0) ? '0 : rf[i_rs2idx];

endmodule
